//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module CoreTb -f tb.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- src/ChannelFifo.sv
`timescale 1ns/100ps
`default_nettype none

module ChannelFifo #(
  parameter int width = 32,
  parameter int depth = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [width-1:0] inData,
  input  logic             inValid,
  output logic             inAck,
  output logic [width-1:0] outData,
  output logic             outValid,
  input  logic             outAck
);

  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntWidth = $clog2(depth + 1);

  logic [width-1:0]    mem [depth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [cntWidth-1:0] count;
  logic                push;
  logic                pop;

  // Wrap at depth, not just at a power of two
  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    if (ptr == ptrWidth'(depth - 1)) begin
      return '0;
    end else begin
      return ptr + 1'b1;
    end
  endfunction

  // Full and empty straight from the count
  assign inAck    = (count != cntWidth'(depth));
  assign outValid = (count != '0);
  assign outData  = mem[rdPtr];

  assign push = inValid && inAck;
  assign pop  = outValid && outAck;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inData;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      // Simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/ConfPkg.sv
`default_nettype none

package ConfPkg;

  // Width of one configuration register
  localparam int confWidth = 16;

  // Register map
  typedef enum logic [7:0] {
    regTimeUnit  = 8'd0,
    regHeartbeat = 8'd1,
    regBdReset   = 8'd2
  } ConfAddr;

  // One register per address in the map
  localparam int confRegCount = 3;

  //////////////////////////////////////////////////////////////////////
  // Reset values

  // Time stopped out of reset
  localparam logic [confWidth-1:0] timeUnitReset = 16'd0;

  // No heartbeats out of reset
  localparam logic [confWidth-1:0] heartbeatReset = 16'd0;

  // Chip held in pReset and sReset
  localparam logic [confWidth-1:0] bdResetReset = 16'd3;

endpackage

`default_nettype wire

//--- src/Core.sv
`timescale 1ns/100ps
`default_nettype none

module Core (
  input  logic                             clk,
  input  logic                             reset,

  // Host side
  input  logic [CorePkg::pcWordWidth-1:0]  pcInData,
  input  logic                             pcInValid,
  output logic                             pcInAck,
  output logic [CorePkg::pcWordWidth-1:0]  pcOutData,
  output logic                             pcOutValid,
  input  logic                             pcOutAck,

  // Chip side
  output logic [CorePkg::bdOutWidth-1:0]   bdOutData,
  output logic                             bdOutValid,
  input  logic                             bdOutAck,
  input  logic [CorePkg::bdInWidth-1:0]    bdInData,
  input  logic                             bdInValid,
  output logic                             bdInAck,

  output logic                             pReset,
  output logic                             sReset
);

  import CorePkg::*;
  import ConfPkg::*;

  // Host words after the input FIFO
  logic [pcWordWidth-1:0] parserInData;
  logic                   parserInValid;
  logic                   parserInAck;

  // Parser to chip FIFO
  logic [bdOutWidth-1:0]  parserBdData;
  logic                   parserBdValid;
  logic                   parserBdAck;

  // Chip words after the upstream FIFO
  logic [bdInWidth-1:0]   packerBdData;
  logic                   packerBdValid;
  logic                   packerBdAck;

  // Packer to host FIFO
  logic [pcWordWidth-1:0] packerOutData;
  logic                   packerOutValid;
  logic                   packerOutAck;

  // Time configuration and state
  logic [confWidth-1:0]   timeUnit;
  logic [confWidth-1:0]   heartbeatUnits;
  logic                   heartbeatPulse;
  logic [timeWidth-1:0]   timeElapsed;

  //////////////////////////////////////////////////////////////////////
  // IO FIFOs

  ChannelFifo #(.width(pcWordWidth), .depth(fifoDepth)) pcInFifo (
    .clk(clk), .reset(reset),
    .inData(pcInData), .inValid(pcInValid), .inAck(pcInAck),
    .outData(parserInData), .outValid(parserInValid), .outAck(parserInAck)
  );

  ChannelFifo #(.width(bdOutWidth), .depth(fifoDepth)) bdOutFifo (
    .clk(clk), .reset(reset),
    .inData(parserBdData), .inValid(parserBdValid), .inAck(parserBdAck),
    .outData(bdOutData), .outValid(bdOutValid), .outAck(bdOutAck)
  );

  ChannelFifo #(.width(bdInWidth), .depth(fifoDepth)) bdInFifo (
    .clk(clk), .reset(reset),
    .inData(bdInData), .inValid(bdInValid), .inAck(bdInAck),
    .outData(packerBdData), .outValid(packerBdValid), .outAck(packerBdAck)
  );

  ChannelFifo #(.width(pcWordWidth), .depth(fifoDepth)) pcOutFifo (
    .clk(clk), .reset(reset),
    .inData(packerOutData), .inValid(packerOutValid), .inAck(packerOutAck),
    .outData(pcOutData), .outValid(pcOutValid), .outAck(pcOutAck)
  );

  //////////////////////////////////////////////////////////////////////
  // Parser, time and packer

  PcParser pcParser (
    .clk(clk), .reset(reset),
    .inData(parserInData), .inValid(parserInValid), .inAck(parserInAck),
    .bdData(parserBdData), .bdValid(parserBdValid), .bdAck(parserBdAck),
    .timeUnit(timeUnit), .heartbeatUnits(heartbeatUnits),
    .pReset(pReset), .sReset(sReset)
  );

  TimeMgr timeMgr (
    .clk(clk), .reset(reset),
    .timeUnit(timeUnit), .heartbeatUnits(heartbeatUnits),
    .heartbeatPulse(heartbeatPulse), .timeElapsed(timeElapsed)
  );

  PcPacker pcPacker (
    .clk(clk), .reset(reset),
    .bdData(packerBdData), .bdValid(packerBdValid), .bdAck(packerBdAck),
    .heartbeatPulse(heartbeatPulse), .timeElapsed(timeElapsed),
    .outData(packerOutData), .outValid(packerOutValid), .outAck(packerOutAck)
  );

endmodule

`default_nettype wire

//--- src/CorePkg.sv
`default_nettype none

package CorePkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath widths

  // Host word is code on top of data
  localparam int pcCodeWidth = 8;
  localparam int pcDataWidth = 24;
  localparam int pcWordWidth = pcCodeWidth + pcDataWidth;

  // Chip side words
  localparam int bdOutWidth = 21;
  localparam int bdInWidth = 34;

  // Elapsed time in time units
  localparam int timeWidth = 48;

  // Depth of every IO FIFO
  localparam int fifoDepth = 4;

  //////////////////////////////////////////////////////////////////////
  // Host word codes

  // Host to FPGA
  // Codes outside this list are dropped by the parser
  typedef enum logic [pcCodeWidth-1:0] {
    codeNop       = 8'h00,
    codeBdWord    = 8'h01,
    codeConfWrite = 8'h02
  } PcDownCode;

  // FPGA to host
  typedef enum logic [pcCodeWidth-1:0] {
    upBdLow     = 8'h40,
    upBdHigh    = 8'h41,
    upHeartbeat = 8'h42
  } PcUpCode;

endpackage

`default_nettype wire

//--- src/PcPacker.sv
`timescale 1ns/100ps
`default_nettype none

module PcPacker (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [CorePkg::bdInWidth-1:0]    bdData,
  input  logic                             bdValid,
  output logic                             bdAck,
  input  logic                             heartbeatPulse,
  input  logic [CorePkg::timeWidth-1:0]    timeElapsed,
  output logic [CorePkg::pcWordWidth-1:0]  outData,
  output logic                             outValid,
  input  logic                             outAck
);

  import CorePkg::*;

  typedef enum logic [1:0] {
    idle,
    sendLow,
    sendHigh,
    sendBeat
  } PackState;

  // Zero fill above the top slice of a chip word
  localparam int highWidth = bdInWidth - pcDataWidth;
  localparam int highPad = pcDataWidth - highWidth;

  PackState               state;
  logic                   beatPending;
  logic [pcDataWidth-1:0] beatData;
  logic                   takeBeat;

  // Output word is live in every state but idle
  assign outValid = (state != idle);

  // Chip word released once its high half is gone
  assign bdAck = (state == sendHigh) && outAck;

  // Heartbeat wins over a waiting chip word
  assign takeBeat = (state == idle) && beatPending;

  //////////////////////////////////////////////////////////////////////
  // Pending heartbeat

  always_ff @(posedge clk) begin
    if (reset) begin
      beatPending <= 1'b0;
    end else if (heartbeatPulse) begin
      beatPending <= 1'b1;
    end else if (takeBeat) begin
      beatPending <= 1'b0;
    end
  end

  // Newest pulse overwrites older time
  always_ff @(posedge clk) begin
    if (heartbeatPulse) begin
      beatData <= timeElapsed[pcDataWidth-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (beatPending) begin
            state <= sendBeat;
          end else if (bdValid) begin
            state <= sendLow;
          end
        end
        sendLow:  if (outAck) state <= sendHigh;
        sendHigh: if (outAck) state <= idle;
        sendBeat: if (outAck) state <= idle;
        default:  state <= idle;
      endcase
    end
  end

  // Host word framing
  always_ff @(posedge clk) begin
    if (takeBeat) begin
      outData <= {upHeartbeat, beatData};
    end else if (state == idle && bdValid) begin
      outData <= {upBdLow, bdData[pcDataWidth-1:0]};
    end else if (state == sendLow && outAck) begin
      outData <= {upBdHigh, {highPad{1'b0}}, bdData[bdInWidth-1:pcDataWidth]};
    end
  end

endmodule

`default_nettype wire

//--- src/PcParser.sv
`timescale 1ns/100ps
`default_nettype none

module PcParser (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [CorePkg::pcWordWidth-1:0]   inData,
  input  logic                              inValid,
  output logic                              inAck,
  output logic [CorePkg::bdOutWidth-1:0]    bdData,
  output logic                              bdValid,
  input  logic                              bdAck,
  output logic [ConfPkg::confWidth-1:0]     timeUnit,
  output logic [ConfPkg::confWidth-1:0]     heartbeatUnits,
  output logic                              pReset,
  output logic                              sReset
);

  import CorePkg::*;
  import ConfPkg::*;

  PcDownCode              code;
  ConfAddr                confAddr;
  logic [pcDataWidth-1:0] payload;
  logic [confWidth-1:0]   confValue;
  logic [confWidth-1:0]   confRegs [confRegCount];
  logic                   bdFree;
  logic                   accept;
  logic                   bdLoad;
  logic                   confWrite;

  //////////////////////////////////////////////////////////////////////
  // Decode

  assign code      = PcDownCode'(inData[pcWordWidth-1:pcDataWidth]);
  assign payload   = inData[pcDataWidth-1:0];
  // Address in the top data byte, value below it
  assign confAddr  = ConfAddr'(payload[pcDataWidth-1:confWidth]);
  assign confValue = payload[confWidth-1:0];

  // Output register free or emptying this cycle
  assign bdFree = !bdValid || bdAck;

  // Only bd words can stall
  assign inAck     = (code == codeBdWord) ? bdFree : 1'b1;
  assign accept    = inValid && inAck;
  assign bdLoad    = accept && (code == codeBdWord);
  assign confWrite = accept && (code == codeConfWrite);

  //////////////////////////////////////////////////////////////////////
  // Configuration registers

  always_ff @(posedge clk) begin
    if (reset) begin
      confRegs[int'(regTimeUnit)]  <= timeUnitReset;
      confRegs[int'(regHeartbeat)] <= heartbeatReset;
      confRegs[int'(regBdReset)]   <= bdResetReset;
    end else begin
      // Unmapped addresses match nothing
      for (int i = 0; i < confRegCount; i++) begin
        if (confWrite && int'(confAddr) == i) begin
          confRegs[i] <= confValue;
        end
      end
    end
  end

  assign timeUnit       = confRegs[int'(regTimeUnit)];
  assign heartbeatUnits = confRegs[int'(regHeartbeat)];
  assign pReset         = confRegs[int'(regBdReset)][0];
  assign sReset         = confRegs[int'(regBdReset)][1];

  //////////////////////////////////////////////////////////////////////
  // Downstream word register

  always_ff @(posedge clk) begin
    if (reset) begin
      bdValid <= 1'b0;
    end else if (bdLoad) begin
      bdValid <= 1'b1;
    end else if (bdAck) begin
      bdValid <= 1'b0;
    end
  end

  // Low 21 bits of data go to the chip
  always_ff @(posedge clk) begin
    if (bdLoad) begin
      bdData <= payload[bdOutWidth-1:0];
    end
  end

endmodule

`default_nettype wire

//--- src/TimeMgr.sv
`timescale 1ns/100ps
`default_nettype none

module TimeMgr (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [ConfPkg::confWidth-1:0]  timeUnit,
  input  logic [ConfPkg::confWidth-1:0]  heartbeatUnits,
  output logic                           heartbeatPulse,
  output logic [CorePkg::timeWidth-1:0]  timeElapsed
);

  import CorePkg::*;
  import ConfPkg::*;

  logic [confWidth-1:0] clkCount;
  logic [confWidth-1:0] beatCount;
  logic [confWidth-1:0] lastBeatUnits;
  logic                 unitPulse;
  logic                 beatDue;

  // Last clock of a unit
  // Also catches a count left above a shrunk timeUnit
  assign unitPulse = (timeUnit != '0) && (clkCount >= timeUnit - 1'b1);

  // Last unit of a heartbeat period
  assign beatDue = (heartbeatUnits != '0) && (beatCount >= heartbeatUnits - 1'b1);

  //////////////////////////////////////////////////////////////////////
  // Clock divider and elapsed time

  always_ff @(posedge clk) begin
    if (reset) begin
      clkCount    <= '0;
      timeElapsed <= '0;
    end else if (timeUnit == '0) begin
      // Time stopped
      clkCount <= '0;
    end else if (unitPulse) begin
      clkCount    <= '0;
      timeElapsed <= timeElapsed + timeWidth'(1);
    end else begin
      clkCount <= clkCount + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Heartbeat

  always_ff @(posedge clk) begin
    if (reset) begin
      beatCount      <= '0;
      lastBeatUnits  <= '0;
      heartbeatPulse <= 1'b0;
    end else begin
      lastBeatUnits  <= heartbeatUnits;
      // Registered with the time increment so both land together
      heartbeatPulse <= unitPulse && beatDue && (heartbeatUnits == lastBeatUnits);
      if (heartbeatUnits != lastBeatUnits || heartbeatUnits == '0) begin
        // New period restarts the count
        beatCount <= '0;
      end else if (unitPulse) begin
        beatCount <= beatDue ? '0 : beatCount + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb.f
src/CorePkg.sv
src/ConfPkg.sv
src/ChannelFifo.sv
src/PcParser.sv
src/TimeMgr.sv
src/PcPacker.sv
src/Core.sv
tests/Core_asserts.sv
tests/CoreTb.sv

//--- tests/CoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module CoreTb;

  import CorePkg::*;
  import ConfPkg::*;

  typedef enum {beatOff, beatExact, beatLoose} BeatMode;

  localparam int numDownWords = 40;
  localparam int numUpWords = 30;
  localparam int numMixWords = 30;
  localparam int numConfWords = 4;
  localparam int beatUnits = 3;
  localparam int unitClocks = 4;
  localparam int stimWords = numDownWords + numUpWords + numMixWords + numConfWords;
  localparam int timeoutNs = 4000 + 200 * stimWords;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic [pcWordWidth-1:0] pcInData = '0;
  logic pcInValid = 1'b0;
  logic pcInAck;
  logic [pcWordWidth-1:0] pcOutData;
  logic pcOutValid;
  logic pcOutAck = 1'b1;
  logic [bdOutWidth-1:0] bdOutData;
  logic bdOutValid;
  logic bdOutAck = 1'b1;
  logic [bdInWidth-1:0] bdInData = '0;
  logic bdInValid = 1'b0;
  logic bdInAck;
  logic pReset;
  logic sReset;

  // Scoreboard and checker state
  string testName = "reset values";
  logic [bdOutWidth-1:0] expBd[$];
  logic [bdInWidth-1:0] expUp[$];
  logic highDue = 1'b0;
  logic pcAckRandom = 1'b0;
  logic bdAckRandom = 1'b0;
  BeatMode beatMode = beatOff;
  logic [pcDataWidth-1:0] lastBeat = '0;
  int beatsSeen = 0;

  Core dut_i (.*);

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model

  // Chip gets the low bits of a bd word
  function automatic logic [bdOutWidth-1:0] bdWordOf(input logic [pcWordWidth-1:0] hostWord);
    return hostWord[bdOutWidth-1:0];
  endfunction

  // Low half on top, high half below
  function automatic logic [2*pcWordWidth-1:0] hostPairOf(input logic [bdInWidth-1:0] chip);
    logic [pcWordWidth-1:0] low;
    logic [pcWordWidth-1:0] high;
    low = {upBdLow, chip[pcDataWidth-1:0]};
    high = {upBdHigh, pcDataWidth'(chip[bdInWidth-1:pcDataWidth])};
    return {low, high};
  endfunction

  function automatic logic [pcDataWidth-1:0] heartbeatDataOf(input logic [timeWidth-1:0] units);
    return units[pcDataWidth-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares

  task automatic abortRun();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic reportProblem(input string msg);
    $display("%s (%s)", msg, testName);
    abortRun();
  endtask

  task automatic checkPcWord(input string name, input logic [pcWordWidth-1:0] expected,
                             input logic [pcWordWidth-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkBdWord(input string name, input logic [bdOutWidth-1:0] expected,
                             input logic [bdOutWidth-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkLevel(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
      abortRun();
    end
  endtask

  // Heartbeat data by the current mode
  task automatic checkBeat(input logic [pcWordWidth-1:0] word);
    logic [pcDataWidth-1:0] beat;
    beat = word[pcDataWidth-1:0];
    if (beatMode == beatOff) begin
      reportProblem("Heartbeat arrived while heartbeats are disabled");
    end else if (beatMode == beatExact) begin
      checkPcWord(testName,
                  {upHeartbeat, heartbeatDataOf(timeWidth'((beatsSeen + 1) * beatUnits))},
                  word);
    end else if (beat % beatUnits != 0 || beat <= lastBeat) begin
      reportProblem("Heartbeat time is not a later multiple of the period");
    end
    lastBeat = beat;
    beatsSeen++;
  endtask

  // One host word off pcOut
  task automatic checkHostWord(input logic [pcWordWidth-1:0] word);
    logic [2*pcWordWidth-1:0] pair;
    case (word[pcWordWidth-1:pcDataWidth])
      upBdLow: begin
        if (highDue) begin
          reportProblem("upBdLow arrived where upBdHigh was due");
        end else if (expUp.size() == 0) begin
          reportProblem("Chip word arrived with no chip word expected");
        end else begin
          pair = hostPairOf(expUp[0]);
          checkPcWord(testName, pair[2*pcWordWidth-1:pcWordWidth], word);
          highDue = 1'b1;
        end
      end
      upBdHigh: begin
        if (!highDue) begin
          reportProblem("upBdHigh arrived without its upBdLow");
        end else begin
          pair = hostPairOf(expUp.pop_front());
          checkPcWord(testName, pair[pcWordWidth-1:0], word);
          highDue = 1'b0;
        end
      end
      upHeartbeat: begin
        if (highDue) begin
          reportProblem("Heartbeat split a chip word pair");
        end else begin
          checkBeat(word);
        end
      end
      default: reportProblem("Host word with an unknown code");
    endcase
  endtask

  // Compare on every transfer edge
  always @(posedge clk) begin
    if (!reset && bdOutValid && bdOutAck) begin
      if (expBd.size() == 0) begin
        reportProblem("bdOut word arrived with no word expected");
      end else begin
        checkBdWord(testName, expBd.pop_front(), bdOutData);
      end
    end
    if (!reset && pcOutValid && pcOutAck) begin
      checkHostWord(pcOutData);
    end
  end

  // Back-pressure on both outputs
  always @(negedge clk) begin
    pcOutAck = pcAckRandom ? 1'($urandom) : 1'b1;
    bdOutAck = bdAckRandom ? 1'($urandom) : 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  // Called at a falling edge and returns at the one after the transfer
  task automatic sendHostWord(input logic [pcWordWidth-1:0] word);
    logic taken;
    pcInData = word;
    pcInValid = 1'b1;
    do begin
      taken = pcInAck;
      @(negedge clk);
    end while (!taken);
    pcInValid = 1'b0;
  endtask

  task automatic sendChipWord(input logic [bdInWidth-1:0] word);
    logic taken;
    bdInData = word;
    bdInValid = 1'b1;
    do begin
      taken = bdInAck;
      @(negedge clk);
    end while (!taken);
    bdInValid = 1'b0;
  endtask

  task automatic confWrite(input logic [7:0] addr, input logic [confWidth-1:0] value);
    sendHostWord({codeConfWrite, addr, value});
  endtask

  task automatic drainQueues();
    while (expBd.size() != 0 || expUp.size() != 0 || highDue) begin
      @(negedge clk);
    end
  endtask

  initial begin
    logic [pcWordWidth-1:0] word;
    logic [pcDataWidth-1:0] data;
    logic [7:0] badAddr;
    logic [bdInWidth-1:0] chip;
    int beatsBefore;
    void'($urandom(32'h3e19_9799));
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // 1. Reset values
    @(negedge clk);
    checkLevel("pcOutValid after reset", 1'b0, pcOutValid);
    checkLevel("bdOutValid after reset", 1'b0, bdOutValid);
    checkLevel("pReset after reset", 1'b1, pReset);
    checkLevel("sReset after reset", 1'b1, sReset);

    // 2. Chip reset register visible two edges after the FIFO takes it
    testName = "reset register";
    confWrite(regBdReset, 16'd0);
    repeat (2) @(negedge clk);
    checkLevel("pReset cleared", 1'b0, pReset);
    checkLevel("sReset cleared", 1'b0, sReset);
    confWrite(regBdReset, 16'd2);
    repeat (2) @(negedge clk);
    checkLevel("pReset after 2", 1'b0, pReset);
    checkLevel("sReset after 2", 1'b1, sReset);

    // 3. Bd words among words the parser drops
    testName = "downstream";
    bdAckRandom = 1'b1;
    for (int i = 0; i < numDownWords; i++) begin
      data = pcDataWidth'($urandom);
      badAddr = 8'(3 + $urandom_range(0, 252));
      case ($urandom_range(0, 4))
        0, 1: begin
          word = {codeBdWord, data};
          expBd.push_back(bdWordOf(word));
        end
        2: word = {codeNop, data};
        3: word = {badAddr, data};
        default: word = {codeConfWrite, badAddr, data[confWidth-1:0]};
      endcase
      sendHostWord(word);
    end
    drainQueues();
    bdAckRandom = 1'b0;
    // Writes to unmapped addresses leave the chip reset levels alone
    checkLevel("pReset after unmapped writes", 1'b0, pReset);
    checkLevel("sReset after unmapped writes", 1'b1, sReset);

    // 4. Chip words split into host word pairs
    testName = "upstream";
    pcAckRandom = 1'b1;
    for (int i = 0; i < numUpWords; i++) begin
      chip = {2'($urandom), $urandom};
      expUp.push_back(chip);
      sendChipWord(chip);
    end
    drainQueues();
    pcAckRandom = 1'b0;

    // 5. Period set before time starts so beats land on multiples
    testName = "heartbeat";
    beatMode = beatExact;
    confWrite(regHeartbeat, 16'(beatUnits));
    confWrite(regTimeUnit, 16'(unitClocks));
    while (beatsSeen < 6) begin
      @(negedge clk);
    end

    // 6. Beats may be overwritten under stall
    testName = "heartbeat traffic";
    beatMode = beatLoose;
    beatsBefore = beatsSeen;
    pcAckRandom = 1'b1;
    for (int i = 0; i < numMixWords; i++) begin
      chip = {2'($urandom), $urandom};
      expUp.push_back(chip);
      sendChipWord(chip);
    end
    drainQueues();
    if (beatsSeen == beatsBefore) begin
      reportProblem("No heartbeat arrived during chip traffic");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #(timeoutNs);
    reportProblem("Watchdog expired before all tests finished");
  end

endmodule

`default_nettype wire

//--- tests/Core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module Core_asserts (
  input wire logic                            clk,
  input wire logic                            reset,
  input wire logic [CorePkg::pcWordWidth-1:0] pcOutData,
  input wire logic                            pcOutValid,
  input wire logic                            pcOutAck,
  input wire logic [CorePkg::bdOutWidth-1:0]  bdOutData,
  input wire logic                            bdOutValid,
  input wire logic                            bdOutAck
);

  //////////////////////////////////////////////////////////////////////
  // Handshake stability

  // Host word held until taken
  pcOutHold: assert property (@(posedge clk) disable iff (reset)
    pcOutValid && !pcOutAck |=> pcOutValid && $stable(pcOutData))
    else $error("pcOut word changed or dropped before its ack");

  // Chip word held until taken
  bdOutHold: assert property (@(posedge clk) disable iff (reset)
    bdOutValid && !bdOutAck |=> bdOutValid && $stable(bdOutData))
    else $error("bdOut word changed or dropped before its ack");

  // Outputs empty once a reset edge has passed
  validInReset: assert property (@(posedge clk)
    reset |=> !pcOutValid && !bdOutValid)
    else $error("Output valid high during reset");

endmodule

bind Core Core_asserts coreAsserts (.*);

`default_nettype wire
